// ==== verilog/dcache_bus_pkg.sv ====
/*
 * Shared definitions for the data-cache bus controller:
 * line and beat geometry, width typedefs, the request, response and
 * tracking structs, and the state encodings of the splitter and assembler.
 */
`default_nettype none

package dcache_bus_pkg;

	// ==================================================================
	// Geometry
	// ==================================================================
	localparam int LINE_BYTES     = 64;
	localparam int BEAT_BYTES     = 16;
	localparam int BEATS_PER_LINE = LINE_BYTES / BEAT_BYTES;

	// ==================================================================
	// Width typedefs
	// ==================================================================
	typedef logic [31:0]                  addr_t;
	typedef logic [1:0]                   beat_idx_t;
	typedef logic [BEATS_PER_LINE-1:0]    beat_mask_t;
	typedef logic [3:0]                   tag_t;
	typedef logic [LINE_BYTES*8-1:0]      line_data_t;
	typedef logic [BEAT_BYTES*8-1:0]      beat_data_t;
	typedef logic [LINE_BYTES-1:0]        line_sel_t;
	typedef logic [BEAT_BYTES-1:0]        beat_sel_t;

	// ==================================================================
	// Bus records
	// ==================================================================
	// Whole-line request from the CPU side, address is line aligned
	typedef struct packed {
		logic       we;
		tag_t       tag;
		addr_t      adr;
		line_sel_t  sel;
		line_data_t dat;
	} line_req_t;

	// One 16-byte beat on the memory side
	typedef struct packed {
		logic       we;
		tag_t       tag;
		beat_idx_t  beat;
		addr_t      adr;
		beat_sel_t  sel;
		beat_data_t dat;
	} beat_req_t;

	// Memory answer to a beat, data is zero for writes
	typedef struct packed {
		tag_t       tag;
		beat_idx_t  beat;
		beat_data_t dat;
	} beat_resp_t;

	// Record passed from splitter to assembler for the line in flight
	typedef struct packed {
		tag_t       tag;
		logic       we;
		beat_mask_t mask;
	} line_track_t;

	// Completed line returned to the CPU
	typedef struct packed {
		tag_t       tag;
		logic       we;
		line_data_t dat;
	} line_resp_t;

	typedef enum logic {SPLIT_IDLE, SPLIT_ISSUE} splitter_state_t;
	typedef enum logic [1:0] {ASM_IDLE, ASM_COLLECT, ASM_RESPOND} assembler_state_t;

endpackage

`default_nettype wire

// ==== verilog/line_splitter.sv ====
/*
 * Line splitter: accepts one CPU line request at a time, hands the
 * tracking record to the assembler and pushes one beat per selected
 * 16-byte strip into the beat queue.
 */
`timescale 1ns/1ps
`default_nettype none

module line_splitter (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire dcache_bus_pkg::line_req_t cpu_req_i,
	input  wire                            cpu_req_valid_i,
	input  wire                            push_ready_i,
	input  wire                            track_ready_i,
	output logic                           cpu_req_ready_o,
	output dcache_bus_pkg::beat_req_t      push_o,
	output logic                           push_valid_o,
	output dcache_bus_pkg::line_track_t    track_o,
	output logic                           track_valid_o
);

	localparam int STRIP_SEL = $bits(dcache_bus_pkg::beat_sel_t);
	localparam int STRIP_DAT = $bits(dcache_bus_pkg::beat_data_t);

	dcache_bus_pkg::splitter_state_t state_r;
	dcache_bus_pkg::line_req_t       line_r;
	dcache_bus_pkg::beat_mask_t      pend_r;
	dcache_bus_pkg::beat_idx_t       beat_r;
	dcache_bus_pkg::beat_mask_t      req_mask;
	dcache_bus_pkg::beat_mask_t      pend_next;
	logic                            accept;
	logic                            push_done;

	// Lowest set beat of a mask, beat 0 when the mask is empty
	function automatic dcache_bus_pkg::beat_idx_t first_beat(
		input dcache_bus_pkg::beat_mask_t mask
	);
		dcache_bus_pkg::beat_idx_t idx;
		idx = '0;
		for (int b = dcache_bus_pkg::BEATS_PER_LINE - 1; b >= 0; b--) begin
			if (mask[b])
				idx = dcache_bus_pkg::beat_idx_t'(b);
		end
		return idx;
	endfunction

	// Loads fetch every beat; writes only touch strips with a selected byte
	always_comb begin
		for (int b = 0; b < dcache_bus_pkg::BEATS_PER_LINE; b++) begin
			req_mask[b] = cpu_req_i.we ? |cpu_req_i.sel[b*STRIP_SEL +: STRIP_SEL] : 1'b1;
		end
	end

	// ==================================================================
	// CPU and track handshakes
	// ==================================================================
	// The track goes out in the same cycle the request is taken
	assign cpu_req_ready_o = (state_r == dcache_bus_pkg::SPLIT_IDLE) && track_ready_i;
	assign track_valid_o   = (state_r == dcache_bus_pkg::SPLIT_IDLE) && cpu_req_valid_i;
	assign accept          = cpu_req_valid_i && cpu_req_ready_o;

	assign track_o.tag  = cpu_req_i.tag;
	assign track_o.we   = cpu_req_i.we;
	assign track_o.mask = req_mask;

	// ==================================================================
	// Beat issue
	// ==================================================================
	assign push_valid_o = (state_r == dcache_bus_pkg::SPLIT_ISSUE);
	assign push_done    = push_valid_o && push_ready_i;
	// Drop the beat just pushed from the pending set
	assign pend_next    = pend_r & ~(dcache_bus_pkg::beat_mask_t'(1) << beat_r);

	always_comb begin
		push_o.we   = line_r.we;
		push_o.tag  = line_r.tag;
		push_o.beat = beat_r;
		push_o.adr  = line_r.adr
			+ dcache_bus_pkg::addr_t'(beat_r) * dcache_bus_pkg::addr_t'(STRIP_SEL);
		// Loads enable every byte lane whatever the request selects
		push_o.sel  = line_r.we ? line_r.sel[beat_r*STRIP_SEL +: STRIP_SEL] : '1;
		push_o.dat  = line_r.dat[beat_r*STRIP_DAT +: STRIP_DAT];
	end

	// Line payload is held for the whole issue phase
	always_ff @(posedge clk_i) begin
		if (accept)
			line_r <= cpu_req_i;
	end

	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i) begin
			state_r <= dcache_bus_pkg::SPLIT_IDLE;
			pend_r  <= '0;
			beat_r  <= '0;
		end else begin
			case (state_r)
			dcache_bus_pkg::SPLIT_IDLE: if (accept) begin
				pend_r <= req_mask;
				beat_r <= first_beat(req_mask);
				// An empty write strip set needs no beats at all
				if (|req_mask)
					state_r <= dcache_bus_pkg::SPLIT_ISSUE;
			end
			dcache_bus_pkg::SPLIT_ISSUE: if (push_done) begin
				pend_r <= pend_next;
				beat_r <= first_beat(pend_next);
				if (pend_next == '0)
					state_r <= dcache_bus_pkg::SPLIT_IDLE;
			end
			default: state_r <= dcache_bus_pkg::SPLIT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/beat_queue.sv ====
/*
 * Beat queue: circular FIFO of bus beats between the splitter and
 * memory. The head entry drives the memory request port directly.
 */
`timescale 1ns/1ps
`default_nettype none

module beat_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                            clk_i,
	input  wire                            rst_i,
	input  wire dcache_bus_pkg::beat_req_t push_i,
	input  wire                            push_valid_i,
	input  wire                            mem_req_ready_i,
	output logic                           push_ready_o,
	output dcache_bus_pkg::beat_req_t      mem_req_o,
	output logic                           mem_req_valid_o
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

	dcache_bus_pkg::beat_req_t entry_r [QUEUE_DEPTH];
	logic [PTR_W-1:0]          wr_ptr_r;
	logic [PTR_W-1:0]          rd_ptr_r;
	logic [PTR_W:0]            count_r;
	logic                      do_push;
	logic                      do_pop;

	// ==================================================================
	// Handshakes
	// ==================================================================
	assign push_ready_o    = (count_r != FULL_CNT);
	assign mem_req_valid_o = (count_r != '0);
	assign mem_req_o       = entry_r[rd_ptr_r];

	assign do_push = push_valid_i && push_ready_o;
	assign do_pop  = mem_req_valid_o && mem_req_ready_i;

	// Storage only, the count decides which entries are live
	always_ff @(posedge clk_i) begin
		if (do_push)
			entry_r[wr_ptr_r] <= push_i;
	end

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end else begin
			if (do_push)
				wr_ptr_r <= wr_ptr_r + 1'b1;
			if (do_pop)
				rd_ptr_r <= rd_ptr_r + 1'b1;
			// Simultaneous push and pop leave the occupancy unchanged
			if (do_push && !do_pop)
				count_r <= count_r + 1'b1;
			else if (do_pop && !do_push)
				count_r <= count_r - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/line_assembler.sv ====
/*
 * Line assembler: takes the tracking record of the line in flight,
 * places each beat response in its slot by beat index and returns the
 * completed line once every expected beat is back.
 */
`timescale 1ns/1ps
`default_nettype none

module line_assembler (
	input  wire                              clk_i,
	input  wire                              rst_i,
	input  wire dcache_bus_pkg::line_track_t track_i,
	input  wire                              track_valid_i,
	input  wire dcache_bus_pkg::beat_resp_t  mem_resp_i,
	input  wire                              mem_resp_valid_i,
	input  wire                              cpu_resp_ready_i,
	output logic                             track_ready_o,
	output dcache_bus_pkg::line_resp_t       cpu_resp_o,
	output logic                             cpu_resp_valid_o
);

	localparam int STRIP_DAT = $bits(dcache_bus_pkg::beat_data_t);

	dcache_bus_pkg::assembler_state_t state_r;
	dcache_bus_pkg::line_track_t      track_r;
	dcache_bus_pkg::beat_mask_t       rcvd_r;
	dcache_bus_pkg::line_data_t       data_r;
	logic                             take_track;
	logic                             capture;

	// ==================================================================
	// Handshakes
	// ==================================================================
	// A new line is taken only once the previous one has been returned
	assign track_ready_o    = (state_r == dcache_bus_pkg::ASM_IDLE);
	assign take_track       = track_valid_i && track_ready_o;
	assign cpu_resp_valid_o = (state_r == dcache_bus_pkg::ASM_RESPOND);

	// Responses are always accepted, but only those of the current line count
	assign capture = mem_resp_valid_i && (state_r == dcache_bus_pkg::ASM_COLLECT)
		&& (mem_resp_i.tag == track_r.tag);

	assign cpu_resp_o.tag = track_r.tag;
	assign cpu_resp_o.we  = track_r.we;
	// Writes carry no line data back
	assign cpu_resp_o.dat = track_r.we ? '0 : data_r;

	// Beat slots may fill in any order
	always_ff @(posedge clk_i) begin
		if (capture)
			data_r[mem_resp_i.beat*STRIP_DAT +: STRIP_DAT] <= mem_resp_i.dat;
	end

	// ==================================================================
	// Collection FSM
	// ==================================================================
	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i) begin
			state_r <= dcache_bus_pkg::ASM_IDLE;
			track_r <= '0;
			rcvd_r  <= '0;
		end else begin
			case (state_r)
			dcache_bus_pkg::ASM_IDLE: if (take_track) begin
				track_r <= track_i;
				rcvd_r  <= '0;
				state_r <= dcache_bus_pkg::ASM_COLLECT;
			end
			dcache_bus_pkg::ASM_COLLECT: begin
				if (capture)
					rcvd_r[mem_resp_i.beat] <= 1'b1;
				// Compare the registered mask so completion lands one cycle later
				if (rcvd_r == track_r.mask)
					state_r <= dcache_bus_pkg::ASM_RESPOND;
			end
			dcache_bus_pkg::ASM_RESPOND: if (cpu_resp_ready_i)
				state_r <= dcache_bus_pkg::ASM_IDLE;
			default: state_r <= dcache_bus_pkg::ASM_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dcache_bus_ctrl.sv ====
/*
 * Data-cache bus controller top level: connects the line splitter,
 * the beat queue and the line assembler.
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_bus_ctrl #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                             clk_i,
	input  wire                             rst_i,
	input  wire dcache_bus_pkg::line_req_t  cpu_req_i,
	input  wire                             cpu_req_valid_i,
	input  wire                             cpu_resp_ready_i,
	input  wire                             mem_req_ready_i,
	input  wire dcache_bus_pkg::beat_resp_t mem_resp_i,
	input  wire                             mem_resp_valid_i,
	output logic                            cpu_req_ready_o,
	output dcache_bus_pkg::line_resp_t      cpu_resp_o,
	output logic                            cpu_resp_valid_o,
	output dcache_bus_pkg::beat_req_t       mem_req_o,
	output logic                            mem_req_valid_o
);

	// Splitter to assembler tracking path
	dcache_bus_pkg::line_track_t track;
	logic                        track_valid;
	logic                        track_ready;

	// Splitter to queue beat path
	dcache_bus_pkg::beat_req_t   push;
	logic                        push_valid;
	logic                        push_ready;

	// ==================================================================
	// Producer, buffer and consumer
	// ==================================================================
	line_splitter u_splitter (
		.clk_i, .rst_i, .cpu_req_i, .cpu_req_valid_i,
		.push_ready_i(push_ready), .track_ready_i(track_ready),
		.cpu_req_ready_o, .push_o(push), .push_valid_o(push_valid),
		.track_o(track), .track_valid_o(track_valid)
	);

	beat_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk_i, .rst_i, .push_i(push), .push_valid_i(push_valid),
		.mem_req_ready_i, .push_ready_o(push_ready),
		.mem_req_o, .mem_req_valid_o
	);

	line_assembler u_assembler (
		.clk_i, .rst_i, .track_i(track), .track_valid_i(track_valid),
		.mem_resp_i, .mem_resp_valid_i, .cpu_resp_ready_i,
		.track_ready_o(track_ready), .cpu_resp_o, .cpu_resp_valid_o
	);

endmodule

`default_nettype wire

// ==== tb/dcache_bus_ctrl_asserts.sv ====
/*
 * Concurrent protocol checks for the data-cache bus controller:
 * payload hold under stalls, select rules per beat and the
 * one-line-at-a-time rule. Bound to the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_bus_ctrl_asserts (
	input wire                             clk_i,
	input wire                             rst_i,
	input wire dcache_bus_pkg::beat_req_t  mem_req_o,
	input wire                             mem_req_valid_o,
	input wire                             mem_req_ready_i,
	input wire dcache_bus_pkg::line_resp_t cpu_resp_o,
	input wire                             cpu_resp_valid_o,
	input wire                             cpu_resp_ready_i,
	input wire                             cpu_req_ready_o
);

	// ==================================================================
	// Handshake hold rules
	// ==================================================================
	// A stalled beat must stay on the bus unchanged
	mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
		else $error("memory request dropped or changed while stalled");

	cpu_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		cpu_resp_valid_o && !cpu_resp_ready_i |=> cpu_resp_valid_o && $stable(cpu_resp_o))
		else $error("line response dropped or changed while stalled");

	// ==================================================================
	// Beat and line rules
	// ==================================================================
	// Load beats always enable every byte lane
	load_full_sel: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_req_valid_o && !mem_req_o.we |-> &mem_req_o.sel)
		else $error("load beat without full byte selects");

	// Write strips with no selected byte never reach the bus
	write_sel_set: assert property (@(posedge clk_i) disable iff (rst_i)
		mem_req_valid_o && mem_req_o.we |-> |mem_req_o.sel)
		else $error("write beat with empty byte selects");

	// No new line is taken while a response waits
	one_line: assert property (@(posedge clk_i) disable iff (rst_i)
		cpu_resp_valid_o |-> !cpu_req_ready_o)
		else $error("request accepted while a line response is pending");

endmodule

bind dcache_bus_ctrl dcache_bus_ctrl_asserts u_asserts (
	.clk_i(clk_i), .rst_i(rst_i),
	.mem_req_o(mem_req_o), .mem_req_valid_o(mem_req_valid_o),
	.mem_req_ready_i(mem_req_ready_i), .cpu_resp_o(cpu_resp_o),
	.cpu_resp_valid_o(cpu_resp_valid_o), .cpu_resp_ready_i(cpu_resp_ready_i),
	.cpu_req_ready_o(cpu_req_ready_o)
);

`default_nettype wire

// ==== tb/tb_dcache_bus_ctrl.sv ====
/*
 * Testbench for the data-cache bus controller: clock and reset,
 * random line stimulus, a behavioral memory with random response
 * order and stalls, value checks and the final report.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_bus_ctrl;

	localparam int TIMEOUT = 400;

	logic clk_i = 1'b0;
	logic rst_i;
	logic cpu_req_valid_i, cpu_resp_ready_i, mem_req_ready_i, mem_resp_valid_i;
	logic cpu_req_ready_o, cpu_resp_valid_o, mem_req_valid_o;
	dcache_bus_pkg::line_req_t  cpu_req_i, cur_req;
	dcache_bus_pkg::line_resp_t cpu_resp_o;
	dcache_bus_pkg::beat_req_t  mem_req_o, req_smp;
	logic                       req_fire;
	dcache_bus_pkg::beat_resp_t mem_resp_i;
	dcache_bus_pkg::beat_resp_t pend_q[$];
	dcache_bus_pkg::beat_mask_t exp_mask, seen;
	logic [7:0] mem_bytes [dcache_bus_pkg::addr_t];
	int order_mode, stall_en, issued_beats, exp_beats;
	int tests, checks, errors, checks_at, errors_at;
	string cur_test;

	dcache_bus_ctrl #(.QUEUE_DEPTH(4)) dut_i (.*);

	always #50 clk_i = ~clk_i;

	task automatic expect_eq(input string what, input logic [511:0] exp,
		input logic [511:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("FAIL %s %s: expected %0h actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout in test %s while waiting for %s", cur_test, what);
		$display("Simulation failed");
		$finish;
	endtask

	// Load data rule: every 32-bit word holds its own byte address
	function automatic logic [511:0] addr_words(input dcache_bus_pkg::addr_t a, input int words);
		logic [511:0] d;
		d = '0;
		for (int w = 0; w < words; w++)
			d[w*32 +: 32] = a + 32'(4 * w);
		return d;
	endfunction

	function automatic dcache_bus_pkg::beat_mask_t expected_mask(
		input dcache_bus_pkg::line_req_t r);
		dcache_bus_pkg::beat_mask_t m;
		for (int b = 0; b < 4; b++)
			m[b] = !r.we || (r.sel[b*16 +: 16] != '0);
		return m;
	endfunction

	// Writes keep only the strips flagged in keep and loads keep random selects
	function automatic dcache_bus_pkg::line_req_t rand_line(input logic we,
		input logic [3:0] keep);
		dcache_bus_pkg::line_req_t r;
		r.we  = we;
		r.tag = 4'($urandom());
		r.adr = $urandom() & 32'hffff_ffc0;
		r.sel = {$urandom(), $urandom()};
		for (int w = 0; w < 16; w++)
			r.dat[w*32 +: 32] = $urandom();
		for (int b = 0; b < 4; b++)
			if (we && !keep[b])
				r.sel[b*16 +: 16] = '0;
		return r;
	endfunction

	// ==================================================================
	// Ready stalls and behavioral memory
	// ==================================================================
	always @(posedge clk_i) begin
		mem_req_ready_i  <= !stall_en || ($urandom_range(2) != 0);
		cpu_resp_ready_i <= !stall_en || ($urandom_range(2) != 0);
	end

	// Memory request port is sampled at the falling edge while it is stable
	always @(negedge clk_i) begin
		req_fire = mem_req_valid_o && mem_req_ready_i;
		req_smp  = mem_req_o;
	end

	always @(posedge clk_i) begin
		dcache_bus_pkg::beat_resp_t r;
		int k;
		mem_resp_valid_i <= 1'b0;
		if (req_fire) begin
			issued_beats++;
			expect_eq("beat adr", cur_req.adr + 32'(16 * req_smp.beat), req_smp.adr);
			expect_eq("beat tag", cur_req.tag, req_smp.tag);
			expect_eq("beat we", cur_req.we, req_smp.we);
			expect_eq("beat sel", cur_req.we ? cur_req.sel[req_smp.beat*16 +: 16] : 16'hffff,
				req_smp.sel);
			if (cur_req.we)
				expect_eq("beat dat", cur_req.dat[req_smp.beat*128 +: 128], req_smp.dat);
			expect_eq("beat expected once", 1, exp_mask[req_smp.beat] && !seen[req_smp.beat]);
			seen[req_smp.beat] = 1'b1;
			for (int i = 0; i < 16; i++)
				if (req_smp.we && req_smp.sel[i])
					mem_bytes[req_smp.adr + i] = req_smp.dat[i*8 +: 8];
			r.tag  = req_smp.tag;
			r.beat = req_smp.beat;
			r.dat  = req_smp.we ? '0 : addr_words(req_smp.adr, 4);
			pend_q.push_back(r);
		end
		// Mode 0 answers in order, 1 newest first, 2 at random
		if (pend_q.size() != 0 && $urandom_range(2) == 0) begin
			k = (order_mode == 0) ? 0 : (order_mode == 1) ? pend_q.size() - 1
				: $urandom_range(pend_q.size() - 1);
			mem_resp_i       <= pend_q[k];
			mem_resp_valid_i <= 1'b1;
			pend_q.delete(k);
		end
	end

	// ==================================================================
	// One line through the controller
	// ==================================================================
	task automatic run_line(input dcache_bus_pkg::line_req_t req);
		logic got;
		logic [511:0] wr_exp;
		logic [511:0] wr_got;
		cur_req   = req;
		exp_mask  = expected_mask(req);
		seen      = '0;
		exp_beats += $countones(exp_mask);
		cpu_req_i       <= req;
		cpu_req_valid_i <= 1'b1;
		got = 1'b0;
		// Ready seen mid-cycle means the request is taken on the next rising edge
		for (int t = 0; t < TIMEOUT && !got; t++) begin
			@(negedge clk_i);
			got = cpu_req_ready_o;
			@(posedge clk_i);
		end
		if (!got)
			timeout_fail("request accept");
		cpu_req_valid_i <= 1'b0;
		got = 1'b0;
		for (int t = 0; t < TIMEOUT && !got; t++) begin
			@(negedge clk_i);
			got = cpu_resp_valid_o && cpu_resp_ready_i;
			if (!got)
				@(posedge clk_i);
		end
		if (!got)
			timeout_fail("line response");
		expect_eq("resp tag", req.tag, cpu_resp_o.tag);
		expect_eq("resp we", req.we, cpu_resp_o.we);
		expect_eq("resp dat", req.we ? '0 : addr_words(req.adr, 16), cpu_resp_o.dat);
		expect_eq("beats seen", exp_mask, seen);
		// Every selected byte of a write must have reached memory
		if (req.we) begin
			wr_exp = '0;
			wr_got = '0;
			for (int i = 0; i < 64; i++) begin
				if (req.sel[i]) begin
					wr_exp[i*8 +: 8] = req.dat[i*8 +: 8];
					if (mem_bytes.exists(req.adr + 32'(i)))
						wr_got[i*8 +: 8] = mem_bytes[req.adr + 32'(i)];
					else
						wr_got[i*8 +: 8] = 8'hxx;
				end
			end
			expect_eq("written bytes", wr_exp, wr_got);
		end
		// The response transfer completes on this edge
		@(posedge clk_i);
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		checks_at = checks;
		errors_at = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s %0d checks, %0d errors", cur_test,
			checks - checks_at, errors - errors_at);
	endtask

	initial begin
		void'($urandom(32'h49c22274));
		rst_i = 1'b1;
		cpu_req_i = '0;
		cur_req = '0;
		cpu_req_valid_i = 1'b0;
		cpu_resp_ready_i = 1'b1;
		mem_req_ready_i = 1'b1;
		mem_resp_i = '0;
		mem_resp_valid_i = 1'b0;
		req_fire = 1'b0;
		req_smp = '0;
		{order_mode, stall_en, issued_beats, exp_beats} = '0;
		{tests, checks, errors} = '0;
		exp_mask = '0;
		seen = '0;
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		@(posedge clk_i);
		start_test("reset");
		expect_eq("mem_req_valid_o", 0, mem_req_valid_o);
		expect_eq("cpu_resp_valid_o", 0, cpu_resp_valid_o);
		expect_eq("cpu_req_ready_o", 1, cpu_req_ready_o);
		end_test();
		start_test("line_load");
		run_line(rand_line(1'b0, 4'hf));
		end_test();
		start_test("partial_write");
		run_line(rand_line(1'b1, 4'($urandom_range(1, 14))));
		run_line(rand_line(1'b1, 4'b0101));
		run_line(rand_line(1'b1, 4'b0000));
		end_test();
		start_test("out_of_order");
		order_mode = 1;
		run_line(rand_line(1'b0, 4'hf));
		order_mode = 2;
		run_line(rand_line(1'b0, 4'hf));
		end_test();
		// Twenty mixed lines under random stalls on both ready inputs
		start_test("back_pressure");
		stall_en = 1;
		issued_beats = 0;
		exp_beats = 0;
		repeat (20)
			run_line(rand_line(1'($urandom()), 4'($urandom())));
		expect_eq("beat count", exp_beats, issued_beats);
		end_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/dcache_bus_pkg.sv
verilog/line_splitter.sv
verilog/beat_queue.sv
verilog/line_assembler.sv
verilog/dcache_bus_ctrl.sv
tb/dcache_bus_ctrl_asserts.sv
tb/tb_dcache_bus_ctrl.sv
